// File: tb.f
verilog/cfg_pkg.sv
verilog/cfg_decode.sv
verilog/cfg_register.sv
verilog/event_tracker.sv
verilog/cfg_response.sv
verilog/cfg_block.sv
bench/tb_clock.sv
bench/cfg_block_props.sv
bench/tb_cfg_block.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = tb_cfg_block
FILELIST  = tb.f
MDIR      = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(MDIR)
	./$(MDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "RESULT: PASS" $(LOG)

clean:
	rm -rf $(MDIR) $(LOG)

// File: bench/tb_cfg_block.sv
// Configuration block testbench
module tb_cfg_block;
  import cfg_pkg::*;

  localparam cfg_data_t CTRL_DEFAULT = 32'h0000_0100;
  localparam int        ACK_TIMEOUT  = 16;

  logic        clk, rst_n, hold, cfg_we, cfg_re, count_event;
  logic        cfg_ack, cfg_err, rsp_err;
  cfg_addr_t   cfg_addr;
  cfg_data_t   cfg_wdata, cfg_rdata, ctrl_value, rsp_data;
  status_t     status_set;
  int          errors, tests, test_start;

  tb_clock #(.PERIOD(20)) u_clock (.clk(clk));

  cfg_block #(.CTRL_DEFAULT(CTRL_DEFAULT)) i_dut (
    .clk(clk), .rst_n(rst_n), .hold(hold), .cfg_we(cfg_we), .cfg_re(cfg_re),
    .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .status_set(status_set),
    .count_event(count_event), .cfg_ack(cfg_ack), .cfg_err(cfg_err),
    .cfg_rdata(cfg_rdata), .ctrl_value(ctrl_value)
  );

  bind cfg_block cfg_block_props u_props (
    .clk(clk), .rst_n(rst_n), .cfg_we(cfg_we), .cfg_re(cfg_re),
    .cfg_ack(cfg_ack), .cfg_err(cfg_err), .cfg_rdata(cfg_rdata)
  );

  // called at a falling edge, holds the strobe for one cycle and waits for the ack
  task automatic issue_request(input logic write, input cfg_addr_t addr, input cfg_data_t data);
    int waited;
    waited   = 0;
    cfg_we   = write;
    cfg_re   = !write;
    cfg_addr = addr;
    cfg_wdata = data;
    @(negedge clk);
    cfg_we = 1'b0;
    cfg_re = 1'b0;
    while (!cfg_ack && waited < ACK_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!cfg_ack) begin
      $display("ERROR: no acknowledge came for the access to address %h", addr);
      errors++;
    end
    // responses are registered, so they are settled at the falling edge
    rsp_err  = cfg_err;
    rsp_data = cfg_rdata;
  endtask

  task automatic cfg_write_req(input cfg_addr_t addr, input cfg_data_t data);
    issue_request(1'b1, addr, data);
  endtask

  task automatic cfg_read_req(input cfg_addr_t addr);
    issue_request(1'b0, addr, '0);
  endtask

  task automatic check_data(input string name, input cfg_data_t got, input cfg_data_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_status(input string name, input status_t got, input status_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // a read of a mapped word must never flag an error
  task automatic expect_read(input cfg_addr_t addr, input cfg_data_t exp);
    cfg_read_req(addr);
    check_data("cfg_rdata", rsp_data, exp);
    check_bit("cfg_err", rsp_err, 1'b0);
  endtask

  task automatic read_status(input status_t exp);
    cfg_read_req(ADDR_STATUS);
    check_status("cfg_rdata[15:0]", rsp_data[STATUS_WIDTH-1:0], exp);
    check_data("cfg_rdata >> 16", rsp_data >> STATUS_WIDTH, '0);
    check_bit("cfg_err", rsp_err, 1'b0);
  endtask

  task automatic pulse_status(input status_t bits);
    status_set = bits;
    @(negedge clk);
    status_set = '0;
  endtask

  // back to back increments, one per cycle
  task automatic pulse_count(input int n);
    repeat (n) begin
      count_event = 1'b1;
      @(negedge clk);
    end
    count_event = 1'b0;
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (errors == test_start) begin
      $display("test %s: passed", name);
    end else begin
      $display("test %s: failed with %0d errors", name, errors - test_start);
    end
    test_start = errors;
  endtask

  task automatic reset_values();
    expect_read(ADDR_CTRL, CTRL_DEFAULT);
    check_data("ctrl_value", ctrl_value, CTRL_DEFAULT);
    read_status('0);
    expect_read(ADDR_COUNT_LO, '0);
    expect_read(ADDR_COUNT_HI, '0);
    finish_test("reset_values");
  endtask

  task automatic ctrl_lock();
    cfg_data_t first;
    first = $urandom;
    cfg_write_req(ADDR_CTRL, first);
    check_bit("cfg_err", rsp_err, 1'b0);
    expect_read(ADDR_CTRL, first);
    check_data("ctrl_value", ctrl_value, first);
    // the first write closed the lock, so this one is refused
    cfg_write_req(ADDR_CTRL, ~first);
    check_bit("cfg_err", rsp_err, 1'b1);
    expect_read(ADDR_CTRL, first);
    check_data("ctrl_value", ctrl_value, first);
    finish_test("ctrl_lock");
  endtask

  task automatic status_w1c();
    status_t exp;
    exp = 16'h00f5;
    pulse_status(exp);
    read_status(exp);
    cfg_write_req(ADDR_STATUS, 32'h0000_0011);
    check_bit("cfg_err", rsp_err, 1'b0);
    exp = exp & ~16'h0011;
    read_status(exp);
    // bit 2 is set and cleared in one cycle, the clear wins, bit 8 is only set
    status_set = 16'h0104;
    cfg_write_req(ADDR_STATUS, 32'h0000_0004);
    status_set = '0;
    exp = (exp | 16'h0104) & ~16'h0004;
    read_status(exp);
    finish_test("status_w1c");
  endtask

  task automatic count_events();
    int     n;
    count_t total;
    n = 3 + ($urandom % 10);
    pulse_count(n);
    expect_read(ADDR_COUNT_HI, '0);
    expect_read(ADDR_COUNT_LO, cfg_data_t'(n));
    expect_read(ADDR_COUNT_LO, '0);
    // start the low word near its top so the count carries into the high word
    cfg_write_req(ADDR_COUNT_LO, 32'hffff_fff0);
    pulse_count(20);
    total = 48'h0000_ffff_fff0 + 48'd20;
    expect_read(ADDR_COUNT_LO, total[31:0]);
    expect_read(ADDR_COUNT_HI, cfg_data_t'(total[COUNT_WIDTH-1:32]));
    expect_read(ADDR_COUNT_HI, '0);
    expect_read(ADDR_COUNT_LO, '0);
    finish_test("count_events");
  endtask

  task automatic unmapped_access();
    cfg_write_req(8'h10, $urandom);
    check_bit("cfg_err", rsp_err, 1'b1);
    check_data("cfg_rdata", rsp_data, '0);
    cfg_read_req(8'h10);
    check_bit("cfg_err", rsp_err, 1'b1);
    check_data("cfg_rdata", rsp_data, '0);
    finish_test("unmapped_access");
  endtask

  task automatic hold_freeze();
    // clear whatever earlier tests left, then set a known pattern
    cfg_write_req(ADDR_STATUS, 32'h0000_ffff);
    pulse_status(16'h0a0a);
    read_status(16'h0a0a);
    hold = 1'b1;
    cfg_write_req(ADDR_STATUS, 32'h0000_0a0a);
    check_bit("cfg_err", rsp_err, 1'b0);
    pulse_status(16'h0001);
    pulse_count(4);
    hold = 1'b0;
    read_status(16'h0a0a);
    expect_read(ADDR_COUNT_LO, '0);
    expect_read(ADDR_COUNT_HI, '0);
    finish_test("hold_freeze");
  endtask

  initial begin
    void'($urandom(32'h1785));
    rst_n       = 1'b0;
    hold        = 1'b0;
    cfg_we      = 1'b0;
    cfg_re      = 1'b0;
    cfg_addr    = '0;
    cfg_wdata   = '0;
    status_set  = '0;
    count_event = 1'b0;
    errors      = 0;
    tests       = 0;
    test_start  = 0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    reset_values();
    ctrl_lock();
    status_w1c();
    count_events();
    unmapped_access();
    hold_freeze();
    $display("tests run: %0d, failed checks: %0d", tests, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // guards the whole run in case a request never completes
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < 2000) begin
      @(posedge clk);
      cycles++;
    end
    $display("ERROR: the run did not finish within 2000 cycles");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: bench/cfg_block_props.sv
// Response protocol assertions
module cfg_block_props
  import cfg_pkg::*;
(
  input logic      clk,
  input logic      rst_n,
  input logic      cfg_we,
  input logic      cfg_re,
  input logic      cfg_ack,
  input logic      cfg_err,
  input cfg_data_t cfg_rdata
);

  // the host never reads and writes in the same cycle
  one_strobe: assume property (@(posedge clk) disable iff (!rst_n) !(cfg_we && cfg_re));

  // every strobe is answered on the very next cycle
  ack_after_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    (cfg_we || cfg_re) |=> cfg_ack) else $error("cfg_ack missing after a strobe");

  // and an idle cycle is never answered
  ack_only_after_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    !(cfg_we || cfg_re) |=> !cfg_ack) else $error("cfg_ack without a strobe");

  err_needs_ack: assert property (@(posedge clk) disable iff (!rst_n)
    cfg_err |-> cfg_ack) else $error("cfg_err without cfg_ack");

  // the merged read data relies on every idle response being zero
  rdata_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
    !cfg_ack |-> (cfg_rdata == '0)) else $error("cfg_rdata not zero while idle");

endmodule

// File: bench/tb_clock.sv
// Testbench clock source
module tb_clock #(
  parameter int PERIOD = 20
) (
  output logic clk
);

  // free running clock that starts low, so the first edge is a rising one
  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

// File: verilog/cfg_block.sv
// Configuration register block
module cfg_block
  import cfg_pkg::*;
#(
  parameter logic [DATA_WIDTH-1:0] CTRL_DEFAULT = 32'h0000_0100
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      hold,
  input  logic      cfg_we,
  input  logic      cfg_re,
  input  cfg_addr_t cfg_addr,
  input  cfg_data_t cfg_wdata,
  input  status_t   status_set,
  input  logic      count_event,
  output logic      cfg_ack,
  output logic      cfg_err,
  output cfg_data_t cfg_rdata,
  output cfg_data_t ctrl_value
);

  logic       ctrl_write, ctrl_read;
  logic       status_write, status_read;
  logic [1:0] count_write, count_read;
  logic       unmapped;

  logic       ctrl_ack, ctrl_err;
  logic       status_ack, status_err;
  logic       count_ack, count_err;
  cfg_data_t  ctrl_rdata, status_rdata, count_rdata;

  status_t    status_f, status_nxt;
  count_t     count_f, count_nxt;
  logic       status_v, count_v;

  cfg_decode u_decode (
    .cfg_we       (cfg_we),
    .cfg_re       (cfg_re),
    .cfg_addr     (cfg_addr),
    .ctrl_write   (ctrl_write),
    .ctrl_read    (ctrl_read),
    .status_write (status_write),
    .status_read  (status_read),
    .count_write  (count_write),
    .count_read   (count_read),
    .unmapped     (unmapped)
  );

  // control word is written once by software, hardware never updates it
  cfg_register #(
    .WIDTH (DATA_WIDTH), .DEFAULT (CTRL_DEFAULT), .RESETABLE (1),
    .LOCKABLE (1), .W1C (0), .ROC (0)
  ) ctrl_reg (
    .clk (clk), .rst_n (rst_n), .hold (hold),
    .reg_v (1'b0), .reg_nxt ('0), .reg_f (ctrl_value),
    .cfg_write (ctrl_write), .cfg_read (ctrl_read), .cfg_wdata (cfg_wdata),
    .cfg_ack (ctrl_ack), .cfg_err (ctrl_err), .cfg_rdata (ctrl_rdata)
  );

  cfg_register #(
    .WIDTH (STATUS_WIDTH), .DEFAULT ('0), .RESETABLE (1),
    .LOCKABLE (0), .W1C (1), .ROC (0)
  ) status_reg (
    .clk (clk), .rst_n (rst_n), .hold (hold),
    .reg_v (status_v), .reg_nxt (status_nxt), .reg_f (status_f),
    .cfg_write (status_write), .cfg_read (status_read), .cfg_wdata (cfg_wdata),
    .cfg_ack (status_ack), .cfg_err (status_err), .cfg_rdata (status_rdata)
  );

  // each counter word clears on its own read
  cfg_register #(
    .WIDTH (COUNT_WIDTH), .DEFAULT ('0), .RESETABLE (1),
    .LOCKABLE (0), .W1C (0), .ROC (1)
  ) count_reg (
    .clk (clk), .rst_n (rst_n), .hold (hold),
    .reg_v (count_v), .reg_nxt (count_nxt), .reg_f (count_f),
    .cfg_write (count_write), .cfg_read (count_read), .cfg_wdata (cfg_wdata),
    .cfg_ack (count_ack), .cfg_err (count_err), .cfg_rdata (count_rdata)
  );

  event_tracker u_tracker (
    .status_f (status_f), .count_f (count_f),
    .status_set (status_set), .count_event (count_event),
    .status_v (status_v), .count_v (count_v),
    .status_nxt (status_nxt), .count_nxt (count_nxt)
  );

  // unmapped rides in bit 3 of both the ack and the error vector
  cfg_response u_response (
    .clk      (clk),
    .rst_n    (rst_n),
    .ack_in   ({unmapped, count_ack, status_ack, ctrl_ack}),
    .err_in   ({unmapped, count_err, status_err, ctrl_err}),
    .rdata_in ({count_rdata, status_rdata, ctrl_rdata}),
    .cfg_ack  (cfg_ack),
    .cfg_err  (cfg_err),
    .cfg_rdata(cfg_rdata)
  );

endmodule

// File: verilog/cfg_response.sv
// Configuration response stage
module cfg_response
  import cfg_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic [3:0]      ack_in,
  input  logic [3:0]      err_in,
  input  cfg_data_t [2:0] rdata_in,
  output logic            cfg_ack,
  output logic            cfg_err,
  output cfg_data_t       cfg_rdata
);

  // bit order of ack_in and err_in is ctrl, status, count, unmapped
  // the unmapped flag sits in bit 3 of both, so a miss acks with error
  logic      ack_any;
  logic      err_any;
  cfg_data_t rdata_any;

  assign ack_any   = |ack_in;
  assign err_any   = |err_in;

  // registers that are not read drive zero, so a plain or merges them
  assign rdata_any = rdata_in[0] | rdata_in[1] | rdata_in[2];

  // one cycle of latency for every response, idle cycles register zeros
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_ack   <= 1'b0;
      cfg_err   <= 1'b0;
      cfg_rdata <= '0;
    end else begin
      cfg_ack   <= ack_any;
      cfg_err   <= err_any;
      cfg_rdata <= rdata_any;
    end
  end

endmodule

// File: verilog/event_tracker.sv
// Status and counter event tracking
module event_tracker
  import cfg_pkg::*;
(
  input  status_t status_f,
  input  count_t  count_f,
  input  status_t status_set,
  input  logic    count_event,
  output logic    status_v,
  output logic    count_v,
  output status_t status_nxt,
  output count_t  count_nxt
);

  // status bits are sticky, a set pulse ors into the current value
  // only the register itself clears them, through a write of ones
  assign status_nxt = status_f | status_set;

  // no update request unless some bit is being set this cycle
  assign status_v   = |status_set;

  // the counter wraps to zero after all ones
  // a read clear in the same cycle overrides this increment
  assign count_nxt  = count_f + count_t'(1);
  assign count_v    = count_event;

endmodule

// File: verilog/cfg_register.sv
// Generic configuration register
module cfg_register
  import cfg_pkg::*;
#(
  parameter int                WIDTH     = 32,
  parameter logic [WIDTH-1:0]  DEFAULT   = '0,
  parameter int                RESETABLE = 1,
  parameter int                LOCKABLE  = 0,
  parameter int                W1C       = 0,
  parameter int                ROC       = 0,
  localparam int               NUM_WORDS = cfg_words(WIDTH)
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 hold,
  input  logic                 reg_v,
  input  logic [WIDTH-1:0]     reg_nxt,
  output logic [WIDTH-1:0]     reg_f,
  input  logic [NUM_WORDS-1:0] cfg_write,
  input  logic [NUM_WORDS-1:0] cfg_read,
  input  cfg_data_t            cfg_wdata,
  output logic                 cfg_ack,
  output logic                 cfg_err,
  output cfg_data_t            cfg_rdata
);

  // the value is handled as whole bus words so any strobe bit selects a word
  localparam int PAD_WIDTH = NUM_WORDS * DATA_WIDTH;

  logic [WIDTH-1:0]     value_f;
  logic [WIDTH-1:0]     value_nxt;
  logic [PAD_WIDTH-1:0] padded_f;
  logic [PAD_WIDTH-1:0] padded_nxt;
  logic                 lock_f;
  logic                 lock_nxt;
  logic                 locked;
  logic                 any_write;
  logic                 any_read;

  always_comb begin
    any_write = |cfg_write;
    any_read  = |cfg_read;
    locked    = (LOCKABLE != 0) & lock_f;

    // zero padding above WIDTH, reads of the top word see zeros there
    padded_f              = '0;
    padded_f[WIDTH-1:0]   = value_f;

    // hardware update goes first so a bus write in the same cycle wins
    padded_nxt            = padded_f;
    if (reg_v) begin
      padded_nxt[WIDTH-1:0] = reg_nxt;
    end

    // a locked register drops the write and flags it
    for (int i = 0; i < NUM_WORDS; i++) begin
      if (cfg_write[i] && !locked) begin
        if (W1C != 0) begin
          padded_nxt[i*DATA_WIDTH +: DATA_WIDTH] =
            padded_nxt[i*DATA_WIDTH +: DATA_WIDTH] & ~cfg_wdata;
        end else begin
          padded_nxt[i*DATA_WIDTH +: DATA_WIDTH] = cfg_wdata;
        end
      end
    end

    // reads return the word as it was before this cycle's changes
    cfg_rdata = '0;
    for (int i = 0; i < NUM_WORDS; i++) begin
      if (cfg_read[i]) begin
        cfg_rdata = padded_f[i*DATA_WIDTH +: DATA_WIDTH];
        if (ROC != 0) begin
          padded_nxt[i*DATA_WIDTH +: DATA_WIDTH] = '0;
        end
      end
    end

    // the first accepted write closes the lock until the next reset
    lock_nxt  = (LOCKABLE != 0) ? (lock_f | any_write) : 1'b0;
    value_nxt = padded_nxt[WIDTH-1:0];

    // while hold is high nothing changes, so nothing is refused either
    cfg_ack   = any_write | any_read;
    cfg_err   = any_write & locked & ~hold;
  end

  generate
    if (RESETABLE != 0) begin : g_reset
      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          value_f <= DEFAULT;
        end else if (!hold) begin
          value_f <= value_nxt;
        end
      end
    end else begin : g_no_reset
      always_ff @(posedge clk) begin
        if (!hold) begin
          value_f <= value_nxt;
        end
      end
    end
  endgenerate

  // the lock state is control state and always resets open
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lock_f <= 1'b0;
    end else if (!hold) begin
      lock_f <= lock_nxt;
    end
  end

  assign reg_f = value_f;

endmodule

// File: verilog/cfg_decode.sv
// Register address decoder
module cfg_decode
  import cfg_pkg::*;
(
  input  logic       cfg_we,
  input  logic       cfg_re,
  input  cfg_addr_t  cfg_addr,
  output logic       ctrl_write,
  output logic       ctrl_read,
  output logic       status_write,
  output logic       status_read,
  output logic [1:0] count_write,
  output logic [1:0] count_read,
  output logic       unmapped
);

  logic hit_ctrl;
  logic hit_status;
  logic hit_count_lo;
  logic hit_count_hi;
  logic hit_any;

  // one compare per mapped word, so at most one hit is ever high
  assign hit_ctrl     = (cfg_addr == ADDR_CTRL);
  assign hit_status   = (cfg_addr == ADDR_STATUS);
  assign hit_count_lo = (cfg_addr == ADDR_COUNT_LO);
  assign hit_count_hi = (cfg_addr == ADDR_COUNT_HI);
  assign hit_any      = hit_ctrl | hit_status | hit_count_lo | hit_count_hi;

  // strobes are qualified by the request, they stay low in idle cycles
  assign ctrl_write   = cfg_we & hit_ctrl;
  assign ctrl_read    = cfg_re & hit_ctrl;
  assign status_write = cfg_we & hit_status;
  assign status_read  = cfg_re & hit_status;

  // the counter takes one strobe bit per word
  // bit 0 selects the low word and bit 1 the high word
  assign count_write  = {cfg_we & hit_count_hi, cfg_we & hit_count_lo};
  assign count_read   = {cfg_re & hit_count_hi, cfg_re & hit_count_lo};

  // a request that misses every word still needs a response
  // the response stage turns this into an ack with error
  assign unmapped     = (cfg_we | cfg_re) & ~hit_any;

endmodule

// File: verilog/cfg_pkg.sv
// Configuration bus definitions
package cfg_pkg;

  // host bus widths, one data word and one word address
  localparam int DATA_WIDTH = 32;
  localparam int ADDR_WIDTH = 8;

  typedef logic [DATA_WIDTH-1:0] cfg_data_t;
  typedef logic [ADDR_WIDTH-1:0] cfg_addr_t;

  // word addresses of the register map
  localparam cfg_addr_t ADDR_CTRL     = 8'h00;
  localparam cfg_addr_t ADDR_STATUS   = 8'h01;
  localparam cfg_addr_t ADDR_COUNT_LO = 8'h02;
  localparam cfg_addr_t ADDR_COUNT_HI = 8'h03;

  // the status register holds one sticky bit per event source
  localparam int STATUS_WIDTH = 16;

  // the event counter spans two bus words, low word first
  localparam int COUNT_WIDTH = 48;

  typedef logic [STATUS_WIDTH-1:0] status_t;
  typedef logic [COUNT_WIDTH-1:0]  count_t;

  // number of bus words needed to hold a register of the given width
  // a partial top word still counts as a full word
  function automatic int cfg_words(input int width);
    int words;
    words = (width + DATA_WIDTH - 1) / DATA_WIDTH;
    if (words < 1) begin
      words = 1;
    end
    return words;
  endfunction

endpackage
